// ==== verilog/rp_cfg.svh ====
////////////////////
// widths, bus map and register offsets shared by the analog datapath
// include in every package and RTL module before use
////////////////////
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// adc pins and samples
`define RP_ADC_RAW_W   16           // full pin word
`define RP_ADC_RSV_W   2            // reserved lsbs, dropped
`define RP_SMP_W       14

// system bus map
`define RP_BUS_W       32
`define RP_REGION_LSB  20           // addr[22:20] picks region
`define RP_REGION_W    3
`define RP_REGION_N    8
`define RP_REGION_HK   0
`define RP_REGION_PWM  4

// pwm outputs
`define RP_PWM_N       4
`define RP_PWM_W       8

// housekeeping
`define RP_HK_ID       32'h52500001 // read-only board id
`define RP_OFS_ID      20'h00000
`define RP_OFS_LOOP    20'h00004
`endif

// ==== verilog/rp_bus_pkg.sv ====
////////////////////
// system bus types, address/data words and per-region masks
// imported by the decoder, register blocks and top
////////////////////
`include "rp_cfg.svh"

package rp_bus_pkg;

  typedef logic [`RP_BUS_W-1:0] sys_addr_t;   // byte address
  typedef logic [`RP_BUS_W-1:0] sys_data_t;

  // region field of the address and one-hot select
  typedef logic [`RP_REGION_W-1:0] region_t;
  typedef logic [`RP_REGION_N-1:0] region_mask_t;  // bit n = region n

endpackage

// ==== verilog/rp_signal_pkg.sv ====
////////////////////
// sample and code types of the adc/dac datapath and pwm duty
////////////////////
`include "rp_cfg.svh"

package rp_signal_pkg;

  // raw adc pin word, offset code with 2 reserved lsbs
  typedef logic [`RP_ADC_RAW_W-1:0] adc_raw_t;

  // two's complement datapath
  typedef logic signed [`RP_SMP_W-1:0] sample_t;
  typedef logic signed [`RP_SMP_W:0]   sample_sum_t;  // one guard bit

  // negative slope offset code going to the dac pins
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  typedef logic [`RP_PWM_W-1:0] pwm_duty_t;   // high cycles per 256

endpackage

// ==== verilog/pwm_generator.sv ====
////////////////////
// single pwm output, 256 cycle period
// high for duty_i cycles of every period
////////////////////
`include "rp_cfg.svh"

module pwm_generator
  import rp_signal_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,
  input  pwm_duty_t duty_i,
  output logic      pwm_o
);

  pwm_duty_t period_cnt;   // free running, wraps at 256

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      period_cnt <= '0;
      pwm_o      <= 1'b0;
    end
    else
    begin
      period_cnt <= period_cnt + 1'b1;
      pwm_o      <= (period_cnt < duty_i);  // duty 0 never high
    end
  end

endmodule

// ==== verilog/sys_bus_decoder.sv ====
////////////////////
// bus region decoder, splits the address space into eight regions
// routes wen/ren pulses and muxes read data and ack by region
////////////////////
`include "rp_cfg.svh"

module sys_bus_decoder
  import rp_bus_pkg::*;
(
  input  sys_addr_t                     sys_addr_i,
  input  logic                          sys_wen_i,    // single cycle pulse
  input  logic                          sys_ren_i,    // single cycle pulse
  input  sys_data_t [`RP_REGION_N-1:0]  slv_rdata_i,
  input  region_mask_t                  slv_ack_i,
  output region_mask_t                  slv_wen_o,
  output region_mask_t                  slv_ren_o,
  output sys_data_t                     sys_rdata_o,
  output logic                          sys_ack_o
);

  // regions with a real slave behind them
  localparam region_mask_t KEPT_MASK =
    region_mask_t'((1 << `RP_REGION_HK) | (1 << `RP_REGION_PWM));

  region_t      region;
  region_mask_t region_cs;   // one-hot
  region_mask_t ack_all;

  ////////////////////
  // select
  ////////////////////

  assign region    = sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W];
  assign region_cs = region_mask_t'(1) << region;

  // pulse goes to the addressed slave only
  assign slv_wen_o = region_cs & {`RP_REGION_N{sys_wen_i}};
  assign slv_ren_o = region_cs & {`RP_REGION_N{sys_ren_i}};

  ////////////////////
  // read back
  ////////////////////

  // empty regions always ack, same cycle
  assign ack_all   = (slv_ack_i & KEPT_MASK) | ~KEPT_MASK;
  assign sys_ack_o = |(region_cs & ack_all);

  // empty regions read as zero
  assign sys_rdata_o = KEPT_MASK[region] ? slv_rdata_i[region] : '0;

endmodule

// ==== verilog/housekeeping_regs.sv ====
////////////////////
// region 0 registers, id word and digital loop control
// ack and read data come one cycle after the pulse
////////////////////
`include "rp_cfg.svh"

module housekeeping_regs
  import rp_bus_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,
  input  sys_addr_t sys_addr_i,
  input  sys_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output sys_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      digital_loop_o   // adc input taken from dac side
);

  logic [`RP_REGION_LSB-1:0] reg_ofs;   // offset inside region

  assign reg_ofs = sys_addr_i[`RP_REGION_LSB-1:0];

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      digital_loop_o <= 1'b0;
      sys_ack_o      <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;   // every access acked
      if (sys_wen_i && (reg_ofs == `RP_OFS_LOOP))
        digital_loop_o <= sys_wdata_i[0];
    end
  end

  // read mux, registered
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (reg_ofs)
        `RP_OFS_ID:   sys_rdata_o <= `RP_HK_ID;
        `RP_OFS_LOOP: sys_rdata_o <= sys_data_t'(digital_loop_o);
        default:      sys_rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== verilog/pwm_regs.sv ====
////////////////////
// region 4 registers, one 8 bit duty per pwm output
// channel n sits at word offset n, the pwm generators live here
////////////////////
`include "rp_cfg.svh"

module pwm_regs
  import rp_bus_pkg::*;
  import rp_signal_pkg::*;
(
  input  logic                           adc_clk,
  input  logic                           reset_i,
  input  sys_addr_t                      sys_addr_i,
  input  sys_data_t                      sys_wdata_i,
  input  logic                           sys_wen_i,
  input  logic                           sys_ren_i,
  output sys_data_t                      sys_rdata_o,
  output logic                           sys_ack_o,
  output pwm_duty_t [`RP_PWM_N-1:0]      pwm_duty_o,
  output logic [`RP_PWM_N-1:0]           pwm_o
);

  localparam int IDX_W = $clog2(`RP_PWM_N);

  logic [`RP_REGION_LSB-3:0] word_ofs;  // byte offset / 4
  logic                      ch_hit;     // offset maps to a channel
  logic [IDX_W-1:0]          ch_idx;

  assign word_ofs = sys_addr_i[`RP_REGION_LSB-1:2];
  assign ch_hit   = (word_ofs < `RP_PWM_N);
  assign ch_idx   = word_ofs[IDX_W-1:0];

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      pwm_duty_o <= '0;
      sys_ack_o  <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i && ch_hit)
        pwm_duty_o[ch_idx] <= sys_wdata_i[`RP_PWM_W-1:0];  // low bits only
    end
  end

  // zero-extended read back
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= ch_hit ? sys_data_t'(pwm_duty_o[ch_idx]) : '0;
  end

  ////////////////////
  // generators
  ////////////////////

  for (genvar i = 0; i < `RP_PWM_N; i++)
  begin : g_pwm
    pwm_generator u_pwm (
      .adc_clk (adc_clk),
      .reset_i (reset_i),
      .duty_i  (pwm_duty_o[i]),
      .pwm_o   (pwm_o[i])
    );
  end

endmodule

// ==== verilog/adc_frontend.sv ====
////////////////////
// adc input stage for both channels
// pin register, offset code to two's complement, loop mux, output register
////////////////////
`include "rp_cfg.svh"

module adc_frontend
  import rp_signal_pkg::*;
(
  input  logic           adc_clk,
  input  logic           reset_i,
  input  adc_raw_t [1:0] adc_raw_i,
  input  logic           digital_loop_i,
  input  sample_t  [1:0] dac_sat_i,       // combinational from dac side
  output sample_t  [1:0] adc_dat_o
);

  logic [1:0][`RP_SMP_W-1:0] adc_reg;    // pin samples, no reset
  sample_t [1:0]             adc_conv;

  // reserved lsbs dropped here
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < 2; ch++)
      adc_reg[ch] <= adc_raw_i[ch][`RP_ADC_RAW_W-1:`RP_ADC_RSV_W];
  end

  // negative slope, keep msb and flip the rest
  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
      adc_conv[ch] = {adc_reg[ch][`RP_SMP_W-1], ~adc_reg[ch][`RP_SMP_W-2:0]};
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      adc_dat_o <= '0;
    else
    begin
      for (int ch = 0; ch < 2; ch++)
        adc_dat_o[ch] <= digital_loop_i ? dac_sat_i[ch] : adc_conv[ch];
    end
  end

endmodule

// ==== verilog/dac_frontend.sv ====
////////////////////
// dac output stage for both channels
// generator + controller sum, saturation to 14 bits, offset code register
////////////////////
`include "rp_cfg.svh"

module dac_frontend
  import rp_signal_pkg::*;
(
  input  logic            adc_clk,
  input  logic            reset_i,
  input  sample_t   [1:0] asg_dat_i,
  input  sample_t   [1:0] pid_dat_i,
  output sample_t   [1:0] dac_sat_o,    // also feeds the digital loop
  output dac_code_t [1:0] dac_code_o
);

  sample_sum_t [1:0] dac_sum;

  ////////////////////
  // sum and clip
  ////////////////////

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      dac_sum[ch] = sample_sum_t'(asg_dat_i[ch]) + sample_sum_t'(pid_dat_i[ch]);
      // top two bits differ -> out of 14 bit range
      if (dac_sum[ch][`RP_SMP_W] ^ dac_sum[ch][`RP_SMP_W-1])
        dac_sat_o[ch] = {dac_sum[ch][`RP_SMP_W], {(`RP_SMP_W-1){~dac_sum[ch][`RP_SMP_W]}}};
      else
        dac_sat_o[ch] = dac_sum[ch][`RP_SMP_W-1:0];
    end
  end

  // signed to negative slope offset code
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      dac_code_o <= '0;
    else
    begin
      for (int ch = 0; ch < 2; ch++)
        dac_code_o[ch] <= {dac_sat_o[ch][`RP_SMP_W-1], ~dac_sat_o[ch][`RP_SMP_W-2:0]};
    end
  end

endmodule

// ==== verilog/rp_analog_top.sv ====
////////////////////
// analog datapath top, adc/dac front ends and the register bus
// single clock domain, bus master and stream sources sit outside
////////////////////
`include "rp_cfg.svh"

module rp_analog_top
  import rp_bus_pkg::*;
  import rp_signal_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  // adc pins
  input  adc_raw_t               adc_dat_a_i,
  input  adc_raw_t               adc_dat_b_i,
  // streams into the dac
  input  sample_t   [1:0]        asg_dat_i,
  input  sample_t   [1:0]        pid_dat_i,
  // system bus
  input  sys_addr_t              sys_addr_i,
  input  sys_data_t              sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output sys_data_t              sys_rdata_o,
  output logic                   sys_ack_o,
  // outputs
  output sample_t   [1:0]        adc_dat_o,    // converted samples
  output dac_code_t [1:0]        dac_code_o,
  output logic [`RP_PWM_N-1:0]   pwm_o
);

  ////////////////////
  // bus decode
  ////////////////////

  region_mask_t                 slv_wen, slv_ren;
  region_mask_t                 slv_ack;
  sys_data_t [`RP_REGION_N-1:0] slv_rdata;
  sys_data_t                    hk_rdata, pwm_rdata;
  logic                         hk_ack, pwm_ack;
  logic                         digital_loop;
  sample_t   [1:0]              dac_sat;

  // only regions 0 and 4 have a slave
  assign slv_rdata = '{`RP_REGION_HK: hk_rdata, `RP_REGION_PWM: pwm_rdata, default: '0};
  assign slv_ack   = '{`RP_REGION_HK: hk_ack, `RP_REGION_PWM: pwm_ack, default: 1'b0};

  sys_bus_decoder u_dec (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .slv_rdata_i (slv_rdata),
    .slv_ack_i   (slv_ack),
    .slv_wen_o   (slv_wen),
    .slv_ren_o   (slv_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  housekeeping_regs u_hk (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (slv_wen[`RP_REGION_HK]),
    .sys_ren_i   (slv_ren[`RP_REGION_HK]),
    .sys_rdata_o (hk_rdata),
    .sys_ack_o   (hk_ack),
    .digital_loop_o (digital_loop)
  );

  pwm_regs u_pwm (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (slv_wen[`RP_REGION_PWM]),
    .sys_ren_i   (slv_ren[`RP_REGION_PWM]),
    .sys_rdata_o (pwm_rdata),
    .sys_ack_o   (pwm_ack),
    .pwm_duty_o  (),            // duties stay inside the block
    .pwm_o       (pwm_o)
  );

  ////////////////////
  // front ends
  ////////////////////

  adc_frontend u_adc (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_raw_i      ({adc_dat_b_i, adc_dat_a_i}),  // [0] = channel a
    .digital_loop_i (digital_loop),
    .dac_sat_i      (dac_sat),
    .adc_dat_o      (adc_dat_o)
  );

  dac_frontend u_dac (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .asg_dat_i  (asg_dat_i),
    .pid_dat_i  (pid_dat_i),
    .dac_sat_o  (dac_sat),
    .dac_code_o (dac_code_o)
  );

endmodule

// ==== tests/tb_checker.sv ====
////////////////////
// watches the analog datapath ports and compares them with reference models
// tracks the register map from observed bus writes, reports per test
////////////////////
`include "rp_cfg.svh"

module tb_checker
  import rp_bus_pkg::*;
  import rp_signal_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  int                     test_id_i,     // 1 = reset state test
  input  adc_raw_t               adc_dat_a_i,
  input  adc_raw_t               adc_dat_b_i,
  input  sample_t   [1:0]        asg_dat_i,
  input  sample_t   [1:0]        pid_dat_i,
  input  sys_addr_t              sys_addr_i,
  input  sys_data_t              sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  input  sys_data_t              sys_rdata_i,   // dut sys_rdata_o
  input  logic                   sys_ack_i,     // dut sys_ack_o
  input  sample_t   [1:0]        adc_out_i,     // dut adc_dat_o
  input  dac_code_t [1:0]        dac_code_i,    // dut dac_code_o
  input  logic [`RP_PWM_N-1:0]   pwm_i          // dut pwm_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SMP_MAX = (1 << (`RP_SMP_W - 1)) - 1;   // 8191
  localparam int SMP_MIN = -SMP_MAX - 1;

  int              err_total    = 0;
  int              err_test     = 0;
  int              tests_run    = 0;
  int              tests_failed = 0;

  adc_raw_t  [1:0] raw_d1, raw_d2;       // pin words, one and two cycles back
  sample_t   [1:0] asg_d1, pid_d1;       // streams, one cycle back
  logic            loop_cur  = 1'b0;     // loop bit model
  logic            loop_hist = 1'b0;     // loop bit one cycle back
  int              warm      = 0;        // cycles since reset release
  pwm_duty_t       duty_m   [`RP_PWM_N];
  int              win_len  [`RP_PWM_N]; // -1 while settling
  int              win_high [`RP_PWM_N];
  logic            ack_pending = 1'b0;   // kept slave answer due
  logic            pend_read   = 1'b0;
  sys_data_t       pend_data;

  ////////////////////
  // reference models
  ////////////////////

  // negative slope offset code, 8191 at code 0 down to -8192
  function automatic sample_t adc_convert(input adc_raw_t raw);
    return sample_t'(SMP_MAX - int'(raw[`RP_ADC_RAW_W-1:`RP_ADC_RSV_W]));
  endfunction

  function automatic sample_t dac_saturate(input sample_t a, input sample_t b);
    int sum;
    sum = int'(a) + int'(b);
    if (sum > SMP_MAX)
      sum = SMP_MAX;       // clip high
    else if (sum < SMP_MIN)
      sum = SMP_MIN;       // clip low
    return sample_t'(sum);
  endfunction

  // signed sample back to the dac offset code
  function automatic dac_code_t dac_code_ref(input sample_t s);
    return dac_code_t'(SMP_MAX - int'(s));
  endfunction

  // high cycles per 256 cycle period equal the duty value
  function automatic int pwm_high_cycles(input pwm_duty_t duty);
    return int'(duty);
  endfunction

  // register map read value, before any write in the same cycle lands
  function automatic sys_data_t reg_read_ref(input region_t rgn,
                                             input logic [`RP_REGION_LSB-1:0] ofs);
    if (rgn == `RP_REGION_HK)
    begin
      if (ofs == `RP_OFS_ID)
        return `RP_HK_ID;
      else if (ofs == `RP_OFS_LOOP)
        return sys_data_t'(loop_cur);
      else
        return '0;
    end
    if (ofs[`RP_REGION_LSB-1:2] < `RP_PWM_N)
      return sys_data_t'(duty_m[ofs[3:2]]);   // zero extended
    return '0;
  endfunction

  ////////////////////
  // reporting
  ////////////////////

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (actv !== expv)
    begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
      err_test++;
      err_total++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    err_test++;
    err_total++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_test == 0)
      $display("test %0d, %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d, %s: failed with %0d errors", tests_run, name, err_test);
    end
    err_test = 0;
  endtask

  task automatic final_counts();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
  endtask

  ////////////////////
  // compare, sampled at the falling edge
  ////////////////////

  always @(negedge adc_clk)
  begin : watch
    region_t                   rgn;
    logic [`RP_REGION_LSB-1:0] ofs;
    sample_t                   sat;
    sample_t                   exp_adc;
    rgn = sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W];
    ofs = sys_addr_i[`RP_REGION_LSB-1:0];
    if (reset_i)
    begin
      if (test_id_i == 1)
      begin
        compare("sys_ack_o", 0, sys_ack_i);      // no access pending
        compare("pwm_o", 0, pwm_i);
        for (int ch = 0; ch < 2; ch++)
        begin
          compare($sformatf("adc_dat_o[%0d]", ch), 0, adc_out_i[ch]);
          compare($sformatf("dac_code_o[%0d]", ch), 0, dac_code_i[ch]);
        end
      end
      warm        = 0;
      loop_cur    = 1'b0;
      ack_pending = 1'b0;
      for (int ch = 0; ch < `RP_PWM_N; ch++)
      begin
        duty_m[ch]   = '0;
        win_len[ch]  = -1;
        win_high[ch] = 0;
      end
    end
    else
    begin
      // datapath, history needs two cycles
      if (warm >= 2)
      begin
        for (int ch = 0; ch < 2; ch++)
        begin
          sat     = dac_saturate(asg_d1[ch], pid_d1[ch]);
          exp_adc = loop_hist ? sat : adc_convert(raw_d2[ch]);
          compare($sformatf("adc_dat_o[%0d]", ch), exp_adc, adc_out_i[ch]);
          compare($sformatf("dac_code_o[%0d]", ch), dac_code_ref(sat), dac_code_i[ch]);
        end
      end
      else
        warm++;

      // kept slave answers one cycle late
      if (ack_pending)
      begin
        ack_pending = 1'b0;
        compare("sys_ack_o", 1, sys_ack_i);
        if (pend_read)
          compare("sys_rdata_o", pend_data, sys_rdata_i);
      end
      if (sys_wen_i || sys_ren_i)
      begin
        if (rgn == `RP_REGION_HK || rgn == `RP_REGION_PWM)
        begin
          compare("sys_ack_o", 0, sys_ack_i);    // not yet
          ack_pending = 1'b1;
          pend_read   = sys_ren_i;
          pend_data   = reg_read_ref(rgn, ofs);
        end
        else
        begin
          compare("sys_ack_o", 1, sys_ack_i);    // empty region, same cycle
          if (sys_ren_i)
            compare("sys_rdata_o", 0, sys_rdata_i);
        end
      end

      // 256 cycle windows per pwm output
      for (int ch = 0; ch < `RP_PWM_N; ch++)
      begin
        if (win_len[ch] >= 0 && pwm_i[ch])
          win_high[ch]++;
        win_len[ch]++;
        if (win_len[ch] == 256)
        begin
          compare($sformatf("pwm_o[%0d] high cycles", ch),
                  pwm_high_cycles(duty_m[ch]), win_high[ch]);
          win_len[ch]  = 0;
          win_high[ch] = 0;
        end
      end
    end

    // history shift
    raw_d2    = raw_d1;
    raw_d1[0] = adc_dat_a_i;
    raw_d1[1] = adc_dat_b_i;
    asg_d1    = asg_dat_i;
    pid_d1    = pid_dat_i;
    loop_hist = loop_cur;

    // writes land at the next rising edge
    if (!reset_i && sys_wen_i)
    begin
      if (rgn == `RP_REGION_HK && ofs == `RP_OFS_LOOP)
        loop_cur = sys_wdata_i[0];
      if (rgn == `RP_REGION_PWM && ofs[`RP_REGION_LSB-1:2] < `RP_PWM_N)
      begin
        duty_m[ofs[3:2]]   = sys_wdata_i[`RP_PWM_W-1:0];
        win_len[ofs[3:2]]  = -1;    // old duty still out for one cycle
        win_high[ofs[3:2]] = 0;
      end
    end
  end

endmodule

// ==== tests/tb_top.sv ====
////////////////////
// testbench top for the analog datapath
// clock, reset, seeded stimulus, bus accesses, watchdog
////////////////////
`include "rp_cfg.svh"

module tb_top
  import rp_bus_pkg::*;
  import rp_signal_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int        CLK_PERIOD  = 100;
  localparam int        N_RAND      = 200;   // random cycles per datapath test
  localparam int        PWM_WAIT    = 270;   // one full window after a duty write
  localparam int        TEST_CYCLES = 10 + 80 + 3 * (N_RAND + 20) + 4 * (PWM_WAIT + 10);
  localparam sys_addr_t HK_BASE     = sys_addr_t'(`RP_REGION_HK) << `RP_REGION_LSB;
  localparam sys_addr_t PWM_BASE    = sys_addr_t'(`RP_REGION_PWM) << `RP_REGION_LSB;
  localparam pwm_duty_t PWM_DUTIES [4] = '{8'd0, 8'd1, 8'd128, 8'd255};

  logic                 adc_clk = 1'b0;
  logic                 reset_i;
  adc_raw_t             adc_dat_a_i, adc_dat_b_i;
  sample_t   [1:0]      asg_dat_i, pid_dat_i;
  sys_addr_t            sys_addr_i;
  sys_data_t            sys_wdata_i;
  logic                 sys_wen_i, sys_ren_i;
  sys_data_t            sys_rdata_o;
  logic                 sys_ack_o;
  sample_t   [1:0]      adc_dat_o;
  dac_code_t [1:0]      dac_code_o;
  logic [`RP_PWM_N-1:0] pwm_o;
  int                   test_id;

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  rp_analog_top uut (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .asg_dat_i   (asg_dat_i),
    .pid_dat_i   (pid_dat_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .adc_dat_o   (adc_dat_o),
    .dac_code_o  (dac_code_o),
    .pwm_o       (pwm_o)
  );

  tb_checker chk (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .test_id_i   (test_id),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .asg_dat_i   (asg_dat_i),
    .pid_dat_i   (pid_dat_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_i (sys_rdata_o),
    .sys_ack_i   (sys_ack_o),
    .adc_out_i   (adc_dat_o),
    .dac_code_i  (dac_code_o),
    .pwm_i       (pwm_o)
  );

  ////////////////////
  // stimulus tasks
  ////////////////////

  // one pulse, address held until ack
  task automatic bus_access(input sys_addr_t addr, input sys_data_t data, input logic is_wr);
    int waited;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= is_wr;
    sys_ren_i   <= ~is_wr;
    for (waited = 0; waited < 8; waited++)
    begin
      @(negedge adc_clk);
      if (sys_ack_o)
        break;
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;   // pulse is one cycle only
      sys_ren_i <= 1'b0;
    end
    if (waited == 8)
      chk.report_fail($sformatf("no ack for the access to address %h", addr));
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
  endtask

  // new random pin words and streams every cycle
  task automatic run_random(input int n);
    repeat (n)
    begin
      @(posedge adc_clk);
      adc_dat_a_i  <= adc_raw_t'($urandom);
      adc_dat_b_i  <= adc_raw_t'($urandom);
      asg_dat_i[0] <= sample_t'($urandom);
      asg_dat_i[1] <= sample_t'($urandom);
      pid_dat_i[0] <= sample_t'($urandom);
      pid_dat_i[1] <= sample_t'($urandom);
    end
  endtask

  task automatic drive_streams(input int a0, input int p0, input int a1, input int p1);
    @(posedge adc_clk);
    asg_dat_i[0] <= sample_t'(a0);
    pid_dat_i[0] <= sample_t'(p0);
    asg_dat_i[1] <= sample_t'(a1);
    pid_dat_i[1] <= sample_t'(p1);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    int ch;
    void'($urandom(32'h831b41da));   // one seed for the run
    test_id     = 1;
    reset_i     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_dat_i   = '0;
    pid_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (4) @(posedge adc_clk);
    reset_i <= 1'b0;
    repeat (2) @(posedge adc_clk);
    chk.end_test("reset state");

    test_id = 2;
    bus_access(HK_BASE + `RP_OFS_ID, '0, 1'b0);      // id word
    bus_access(HK_BASE + `RP_OFS_LOOP, 32'h1, 1'b1);
    bus_access(HK_BASE + `RP_OFS_LOOP, '0, 1'b0);
    bus_access(HK_BASE + `RP_OFS_LOOP, '0, 1'b1);
    bus_access(HK_BASE + `RP_OFS_LOOP, '0, 1'b0);
    bus_access(32'h0020_0000, '0, 1'b0);             // empty regions
    bus_access(32'h0060_0010, '0, 1'b0);
    for (int i = 0; i < `RP_PWM_N; i++)
      bus_access(PWM_BASE + sys_addr_t'(4 * i), $urandom, 1'b1);  // upper bits dropped
    for (int i = 0; i <= `RP_PWM_N; i++)
      bus_access(PWM_BASE + sys_addr_t'(4 * i), '0, 1'b0);        // last one reads zero
    repeat (3) @(posedge adc_clk);
    chk.end_test("register bus");

    test_id = 3;
    run_random(N_RAND);
    repeat (3) @(posedge adc_clk);
    chk.end_test("adc conversion");

    test_id = 4;
    drive_streams(8191, 8191, -8192, -8192);         // both rails
    drive_streams(8191, 1, -8192, -1);
    drive_streams(8191, -8192, 0, 0);
    run_random(N_RAND);
    repeat (3) @(posedge adc_clk);
    chk.end_test("dac sum and saturation");

    test_id = 5;
    bus_access(HK_BASE + `RP_OFS_LOOP, 32'h1, 1'b1);
    run_random(N_RAND);
    bus_access(HK_BASE + `RP_OFS_LOOP, '0, 1'b1);
    repeat (3) @(posedge adc_clk);
    chk.end_test("digital loop");

    test_id = 6;
    foreach (PWM_DUTIES[i])
    begin
      ch = $urandom % `RP_PWM_N;
      bus_access(PWM_BASE + sys_addr_t'(4 * ch), sys_data_t'(PWM_DUTIES[i]), 1'b1);
      repeat (PWM_WAIT) @(posedge adc_clk);          // window closes in here
    end
    chk.end_test("pwm duty");

    chk.final_counts();
    if (chk.err_total == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog, twice the summed test length
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/rp_bus_pkg.sv
verilog/rp_signal_pkg.sv
verilog/pwm_generator.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping_regs.sv
verilog/pwm_regs.sv
verilog/adc_frontend.sv
verilog/dac_frontend.sv
verilog/rp_analog_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the analog datapath testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_top -o tb_top
./obj_dir/tb_top | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
